/* run_sim.sh */
#!/usr/bin/env bash
# build and run the memslave testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f verilog.f --top-module tb_memslave -o tb_memslave; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/tb_memslave 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
fi

if grep -qxF "PASS: all tests" <<< "$output"; then
  exit 0
else
  echo "simulation did not pass"
  exit 1
fi

/* tests/tb_memslave.sv */
`timescale 1ns/1ps

module tb_memslave
  import memslave_pkg::*;
();

  // about 40 transactions of at most about 60 cycles each under stall plus margin
  localparam int TIMEOUT_CYCLES = 5000;

  logic              clk;
  logic              rst_n_i;
  logic [ADDR_W-1:0] araddr_i;
  logic              arvalid_i;
  logic              arready_o;
  logic              rready_i;
  logic [DATA_W-1:0] rdata_o;
  logic [1:0]        rresp_o;
  logic              rvalid_o;
  logic [ADDR_W-1:0] awaddr_i;
  logic              awvalid_i;
  logic              awready_o;
  logic [DATA_W-1:0] wdata_i;
  logic [STRB_W-1:0] wstrb_i;
  logic              wvalid_i;
  logic              wready_o;
  logic              bready_i;
  logic [1:0]        bresp_o;
  logic              bvalid_o;
  logic [7:0]        tx_data_o;
  logic              tx_valid_o;

  int          seed = 32'h57b13233;
  int          cycles = 0;
  int          tx_pulses = 0;
  int          uart_writes = 0;
  logic [7:0]  tx_last;
  logic [63:0] sram_model [256];
  logic [7:0]  touched [$];

  memslave_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Error: timeout after %0d cycles, a handshake never completed", cycles);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  end

  // count transmitted characters mid-cycle
  always @(negedge clk) begin
    if (tx_valid_o) begin
      tx_pulses <= tx_pulses + 1;
      tx_last   <= tx_data_o;
    end
  end

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic expect_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act == exp) else begin
      $display("Fail %s: expected %h, got %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic require(input logic cond, input string what);
    assert (cond) else begin
      $display("Error: %s", what);
      abort_run();
    end
  endtask

  task automatic ready_outputs_low(input string when);
    require(!arready_o && !awready_o && !wready_o, {"a ready output is high ", when});
  endtask

  function automatic logic [63:0] merge_lanes(input logic [63:0] old_w,
                                              input logic [63:0] new_w,
                                              input logic [7:0]  strb);
    logic [63:0] res;
    res = old_w;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [31:0] sram_addr(input logic [7:0] idx);
    return SRAM_BASE + 32'({idx, 3'b000});
  endfunction

  // valid stays up during the hold so a second request must not be taken
  task automatic bus_read(input logic [31:0] addr, input int hold,
                          output logic [63:0] data, output logic [1:0] resp);
    logic ready_q;
    araddr_i  = addr;
    arvalid_i = 1'b1;
    // acceptance on the very first edge is not sampled
    ready_q = 1'b1;
    @(negedge clk);
    while (!rvalid_o) begin
      ready_q = arready_o;
      @(negedge clk);
    end
    require(ready_q, "read response arrived without arready_o");
    data = rdata_o;
    resp = rresp_o;
    repeat (hold) begin
      @(negedge clk);
      require(rvalid_o, "rvalid_o dropped before rready_i");
      expect_eq("rdata_o", data, rdata_o);
      expect_eq("rresp_o", 64'(resp), 64'(rresp_o));
      ready_outputs_low("while a read response waits");
    end
    arvalid_i = 1'b0;
    rready_i  = 1'b1;
    @(negedge clk);
    rready_i = 1'b0;
    require(!rvalid_o, "rvalid_o stayed high after rready_i");
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [63:0] data,
                           input logic [7:0] strb, input int hold, output logic [1:0] resp);
    logic ready_q;
    awaddr_i  = addr;
    wdata_i   = data;
    wstrb_i   = strb;
    awvalid_i = 1'b1;
    wvalid_i  = 1'b1;
    ready_q = 1'b1;
    @(negedge clk);
    while (!bvalid_o) begin
      require(awready_o == wready_o, "awready_o and wready_o differ");
      ready_q = awready_o;
      @(negedge clk);
    end
    require(ready_q, "write response arrived without awready_o");
    resp = bresp_o;
    repeat (hold) begin
      @(negedge clk);
      require(bvalid_o, "bvalid_o dropped before bready_i");
      expect_eq("bresp_o", 64'(resp), 64'(bresp_o));
      ready_outputs_low("while a write response waits");
    end
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    bready_i  = 1'b1;
    @(negedge clk);
    bready_i = 1'b0;
    require(!bvalid_o, "bvalid_o stayed high after bready_i");
  endtask

  task automatic readback_touched();
    logic [63:0] got;
    logic [1:0]  resp;
    foreach (touched[i]) begin
      bus_read(sram_addr(touched[i]), 0, got, resp);
      expect_eq("rdata_o", sram_model[touched[i]], got);
      expect_eq("rresp_o", 64'(RESP_OKAY), 64'(resp));
    end
  endtask

  task automatic reset_values();
    repeat (4) begin
      @(negedge clk);
      ready_outputs_low("during reset");
      require(!rvalid_o && !bvalid_o && !tx_valid_o, "a valid output is high during reset");
    end
    rst_n_i = 1'b1;
    @(negedge clk);
    ready_outputs_low("after reset");
    require(!rvalid_o && !bvalid_o && !tx_valid_o, "a valid output is high after reset");
  endtask

  task automatic full_strobe_readback();
    logic [7:0]  idx;
    logic [63:0] data;
    logic [1:0]  resp;
    repeat (6) begin
      idx  = 8'($random(seed));
      data = {$random(seed), $random(seed)};
      bus_write(sram_addr(idx), data, 8'hff, 0, resp);
      expect_eq("bresp_o", 64'(RESP_OKAY), 64'(resp));
      sram_model[idx] = data;
      touched.push_back(idx);
    end
    readback_touched();
  endtask

  task automatic partial_strobe_merge();
    logic [7:0]  idx;
    logic [7:0]  strb;
    logic [63:0] data;
    logic [63:0] got;
    logic [1:0]  resp;
    for (int i = 0; i < 2; i++) begin
      idx  = touched[i];
      strb = (i == 0) ? 8'h5a : 8'h81;
      data = {$random(seed), $random(seed)};
      bus_write(sram_addr(idx), data, strb, 0, resp);
      expect_eq("bresp_o", 64'(RESP_OKAY), 64'(resp));
      sram_model[idx] = merge_lanes(sram_model[idx], data, strb);
      bus_read(sram_addr(idx), 0, got, resp);
      expect_eq("rdata_o", sram_model[idx], got);
    end
  endtask

  task automatic uart_port();
    logic [63:0] data;
    logic [63:0] got;
    logic [1:0]  resp;
    for (int i = 0; i < 3; i++) begin
      data = {$random(seed), $random(seed)};
      bus_write(UART_ADDR, data, 8'hff, 0, resp);
      uart_writes++;
      expect_eq("bresp_o", 64'(RESP_OKAY), 64'(resp));
      expect_eq("tx_valid_o pulses", 64'(uart_writes), 64'(tx_pulses));
      expect_eq("tx_data_o", 64'(data[7:0]), 64'(tx_last));
    end
    // low address bits are ignored
    bus_read(UART_ADDR + 32'd5, 0, got, resp);
    expect_eq("rdata_o", 64'(uart_writes), got);
    expect_eq("rresp_o", 64'(RESP_OKAY), 64'(resp));
  endtask

  task automatic unmapped_access();
    logic [31:0] bad_addr [3] = '{32'h0000_1000, SRAM_BASE + 32'h800, UART_ADDR + 32'h8};
    logic [63:0] got;
    logic [1:0]  resp;
    foreach (bad_addr[i]) begin
      bus_read(bad_addr[i], 0, got, resp);
      expect_eq("rresp_o", 64'(RESP_DECERR), 64'(resp));
      expect_eq("rdata_o", 64'h0, got);
      bus_write(bad_addr[i], {$random(seed), $random(seed)}, 8'hff, 0, resp);
      expect_eq("bresp_o", 64'(RESP_DECERR), 64'(resp));
    end
    expect_eq("tx_valid_o pulses", 64'(uart_writes), 64'(tx_pulses));
    readback_touched();
  endtask

  task automatic back_pressure();
    logic [63:0] data;
    logic [63:0] got;
    logic [1:0]  resp;
    bus_read(sram_addr(touched[0]), 10, got, resp);
    expect_eq("rdata_o", sram_model[touched[0]], got);
    data = {$random(seed), $random(seed)};
    bus_write(sram_addr(touched[1]), data, 8'hff, 10, resp);
    expect_eq("bresp_o", 64'(RESP_OKAY), 64'(resp));
    sram_model[touched[1]] = data;
    readback_touched();
  endtask

  initial begin
    rst_n_i   = 1'b0;
    araddr_i  = '0;
    arvalid_i = 1'b0;
    rready_i  = 1'b0;
    awaddr_i  = '0;
    awvalid_i = 1'b0;
    wdata_i   = '0;
    wstrb_i   = '0;
    wvalid_i  = 1'b0;
    bready_i  = 1'b0;
    reset_values();
    full_strobe_readback();
    partial_strobe_merge();
    uart_port();
    unmapped_access();
    back_pressure();
    $display("PASS: all tests");
    $finish;
  end

endmodule

/* verilog.f */
verilog/memslave_pkg.sv
verilog/bus_decode.sv
verilog/sram_bank.sv
verilog/uart_tx_port.sv
verilog/resp_gen.sv
verilog/memslave_top.sv
tests/tb_memslave.sv

/* verilog/bus_decode.sv */
`timescale 1ns/1ps

module bus_decode
  import memslave_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic [ADDR_W-1:0]     araddr_i,
  input  logic                  arvalid_i,
  input  logic [ADDR_W-1:0]     awaddr_i,
  input  logic                  awvalid_i,
  input  logic [DATA_W-1:0]     wdata_i,
  input  logic [STRB_W-1:0]     wstrb_i,
  input  logic                  wvalid_i,
  input  logic                  busy_i,
  output logic                  arready_o,
  output logic                  awready_o,
  output logic                  wready_o,
  output logic                  op_valid_o,
  output logic                  op_write_o,
  output logic [1:0]            op_region_o,
  output logic [SRAM_IDX_W-1:0] op_index_o,
  output logic [DATA_W-1:0]     op_wdata_o,
  output logic [STRB_W-1:0]     op_wstrb_o,
  output logic                  sram_we_o,
  output logic                  sram_re_o,
  output logic                  uart_we_o
);

  logic [19:0]       lfsr;
  logic              stall_ok;
  logic              can_accept;
  logic              read_go;
  logic              write_go;
  logic [ADDR_W-1:0] addr;

  // free-running stall generator
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lfsr <= LFSR_SEED;
    end else begin
      lfsr <= {lfsr[18:0], lfsr[19] ^ lfsr[18]};
    end
  end

  assign stall_ok   = STALL_EN ? lfsr[19] : 1'b1;
  assign can_accept = stall_ok && !busy_i;

  // read wins a tie, write needs both channels present
  assign read_go  = can_accept && arvalid_i;
  assign write_go = can_accept && !arvalid_i && awvalid_i && wvalid_i;

  assign arready_o = read_go;
  assign awready_o = write_go;
  assign wready_o  = write_go;

  assign addr = arvalid_i ? araddr_i : awaddr_i;

  // address map lookup
  always_comb begin
    if (addr >= SRAM_BASE && addr < SRAM_END) begin
      op_region_o = REGION_SRAM;
    end else if (addr[ADDR_W-1:3] == UART_ADDR[ADDR_W-1:3]) begin
      op_region_o = REGION_UART;
    end else begin
      op_region_o = REGION_NONE;
    end
  end

  assign op_valid_o = read_go || write_go;
  assign op_write_o = write_go;
  // word index within the bank
  assign op_index_o = addr[SRAM_IDX_W+2:3];
  assign op_wdata_o = wdata_i;
  assign op_wstrb_o = wstrb_i;

  assign sram_re_o = read_go && (op_region_o == REGION_SRAM);
  assign sram_we_o = write_go && (op_region_o == REGION_SRAM);
  assign uart_we_o = write_go && (op_region_o == REGION_UART);

endmodule

/* verilog/memslave_pkg.sv */
package memslave_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;
  localparam int STRB_W = 8;

  // sram region, one 64-bit word per 8-byte slot
  localparam logic [ADDR_W-1:0] SRAM_BASE = 32'h8000_0000;
  localparam int SRAM_WORDS = 256;
  localparam int SRAM_IDX_W = $clog2(SRAM_WORDS);
  localparam logic [ADDR_W-1:0] SRAM_END = SRAM_BASE + SRAM_WORDS * STRB_W;

  // single uart slot, low three bits ignored
  localparam logic [ADDR_W-1:0] UART_ADDR = 32'hA000_03F8;

  // region codes from decode to result stage
  localparam logic [1:0] REGION_SRAM = 2'd0;
  localparam logic [1:0] REGION_UART = 2'd1;
  localparam logic [1:0] REGION_NONE = 2'd2;

  // response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_DECERR = 2'b11;

  // ready stretching by lfsr
  localparam logic STALL_EN = 1'b1;
  localparam logic [19:0] LFSR_SEED = 20'd101;

endpackage

/* verilog/memslave_top.sv */
`timescale 1ns/1ps

module memslave_top
  import memslave_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic [ADDR_W-1:0] araddr_i,
  input  logic              arvalid_i,
  output logic              arready_o,
  input  logic              rready_i,
  output logic [DATA_W-1:0] rdata_o,
  output logic [1:0]        rresp_o,
  output logic              rvalid_o,
  input  logic [ADDR_W-1:0] awaddr_i,
  input  logic              awvalid_i,
  output logic              awready_o,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic [STRB_W-1:0] wstrb_i,
  input  logic              wvalid_i,
  output logic              wready_o,
  input  logic              bready_i,
  output logic [1:0]        bresp_o,
  output logic              bvalid_o,
  output logic [7:0]        tx_data_o,
  output logic              tx_valid_o
);

  logic                  op_valid;
  logic                  op_write;
  logic [1:0]            op_region;
  logic [SRAM_IDX_W-1:0] op_index;
  logic [DATA_W-1:0]     op_wdata;
  logic [STRB_W-1:0]     op_wstrb;
  logic                  sram_we;
  logic                  sram_re;
  logic                  uart_we;
  logic [DATA_W-1:0]     sram_rdata;
  logic [31:0]           tx_count;
  logic                  busy;

  bus_decode u_decode (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .araddr_i   (araddr_i),
    .arvalid_i  (arvalid_i),
    .awaddr_i   (awaddr_i),
    .awvalid_i  (awvalid_i),
    .wdata_i    (wdata_i),
    .wstrb_i    (wstrb_i),
    .wvalid_i   (wvalid_i),
    .busy_i     (busy),
    .arready_o  (arready_o),
    .awready_o  (awready_o),
    .wready_o   (wready_o),
    .op_valid_o (op_valid),
    .op_write_o (op_write),
    .op_region_o(op_region),
    .op_index_o (op_index),
    .op_wdata_o (op_wdata),
    .op_wstrb_o (op_wstrb),
    .sram_we_o  (sram_we),
    .sram_re_o  (sram_re),
    .uart_we_o  (uart_we)
  );

  sram_bank u_sram (
    .clk    (clk),
    .re_i   (sram_re),
    .we_i   (sram_we),
    .index_i(op_index),
    .wdata_i(op_wdata),
    .wstrb_i(op_wstrb),
    .rdata_o(sram_rdata)
  );

  // uart takes only the low byte of the bus
  uart_tx_port u_uart (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .we_i      (uart_we),
    .wdata_i   (op_wdata[7:0]),
    .tx_data_o (tx_data_o),
    .tx_valid_o(tx_valid_o),
    .tx_count_o(tx_count)
  );

  resp_gen u_resp (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .op_valid_i  (op_valid),
    .op_write_i  (op_write),
    .op_region_i (op_region),
    .sram_rdata_i(sram_rdata),
    .tx_count_i  (tx_count),
    .rready_i    (rready_i),
    .bready_i    (bready_i),
    .rdata_o     (rdata_o),
    .rresp_o     (rresp_o),
    .rvalid_o    (rvalid_o),
    .bresp_o     (bresp_o),
    .bvalid_o    (bvalid_o),
    .busy_o      (busy)
  );

endmodule

/* verilog/resp_gen.sv */
`timescale 1ns/1ps

module resp_gen
  import memslave_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              op_valid_i,
  input  logic              op_write_i,
  input  logic [1:0]        op_region_i,
  input  logic [DATA_W-1:0] sram_rdata_i,
  input  logic [31:0]       tx_count_i,
  input  logic              rready_i,
  input  logic              bready_i,
  output logic [DATA_W-1:0] rdata_o,
  output logic [1:0]        rresp_o,
  output logic              rvalid_o,
  output logic [1:0]        bresp_o,
  output logic              bvalid_o,
  output logic              busy_o
);

  logic [1:0] rregion_q;
  logic [1:0] op_resp;

  assign op_resp = (op_region_i == REGION_NONE) ? RESP_DECERR : RESP_OKAY;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      rresp_o   <= RESP_OKAY;
      bresp_o   <= RESP_OKAY;
      rregion_q <= REGION_NONE;
    end else begin
      // read channel
      if (op_valid_i && !op_write_i) begin
        rvalid_o  <= 1'b1;
        rresp_o   <= op_resp;
        rregion_q <= op_region_i;
      end else if (rvalid_o && rready_i) begin
        rvalid_o <= 1'b0;
      end
      // write response channel
      if (op_valid_i && op_write_i) begin
        bvalid_o <= 1'b1;
        bresp_o  <= op_resp;
      end else if (bvalid_o && bready_i) begin
        bvalid_o <= 1'b0;
      end
    end
  end

  // sram word and count stay put while busy blocks new requests
  always_comb begin
    case (rregion_q)
      REGION_SRAM: rdata_o = sram_rdata_i;
      REGION_UART: rdata_o = {{(DATA_W-32){1'b0}}, tx_count_i};
      default:     rdata_o = '0;
    endcase
  end

  assign busy_o = rvalid_o || bvalid_o;

endmodule

/* verilog/sram_bank.sv */
`timescale 1ns/1ps

module sram_bank
  import memslave_pkg::*;
(
  input  logic                  clk,
  input  logic                  re_i,
  input  logic                  we_i,
  input  logic [SRAM_IDX_W-1:0] index_i,
  input  logic [DATA_W-1:0]     wdata_i,
  input  logic [STRB_W-1:0]     wstrb_i,
  output logic [DATA_W-1:0]     rdata_o
);

  logic [DATA_W-1:0] mem [SRAM_WORDS];

  // byte lanes written under their strobe
  always_ff @(posedge clk) begin
    if (we_i) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (wstrb_i[i]) begin
          mem[index_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
        end
      end
    end
  end

  // read word is held until the next read enable
  always_ff @(posedge clk) begin
    if (re_i) begin
      rdata_o <= mem[index_i];
    end
  end

endmodule

/* verilog/uart_tx_port.sv */
`timescale 1ns/1ps

module uart_tx_port
  import memslave_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic        we_i,
  input  logic [7:0]  wdata_i,
  output logic [7:0]  tx_data_o,
  output logic        tx_valid_o,
  output logic [31:0] tx_count_o
);

  // one-cycle strobe per character and running count
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_valid_o <= 1'b0;
      tx_count_o <= '0;
    end else begin
      tx_valid_o <= we_i;
      if (we_i) begin
        // wraps after 2^32 characters
        tx_count_o <= tx_count_o + 32'd1;
      end
    end
  end

  // character byte
  always_ff @(posedge clk) begin
    if (we_i) begin
      tx_data_o <= wdata_i;
    end
  end

endmodule
